//--- vlog.f
verilog/pinmux_pad_pkg.sv
verilog/pinmux_cfg_pkg.sv
verilog/pinmux_in_route.sv
verilog/pinmux_arduino_out.sv
verilog/pinmux_aux_out.sv
verilog/pinmux_top.sv
testbench/tb_pinmux_top.sv

//--- Bender.yml
package:
  name: pinmux

sources:
  - files:
      - verilog/pinmux_pad_pkg.sv
      - verilog/pinmux_cfg_pkg.sv
      - verilog/pinmux_in_route.sv
      - verilog/pinmux_arduino_out.sv
      - verilog/pinmux_aux_out.sv
      - verilog/pinmux_top.sv
  - target: test
    files:
      - testbench/tb_pinmux_top.sv

//--- testbench/tb_pinmux_top.sv
/*
  Testbench for the pin multiplexer top level
  DUT is purely combinational and clock and reset only pace the stimulus
  Inputs change 1 unit after a rising edge
  Outputs compared 1 unit before the next edge
  Reference model carries its own copy of the pad map
*/
module tb_pinmux_top;

  typedef struct packed {
    logic [37:0] pad_out;
    logic [37:0] pad_oen;
    logic [31:0] gpio_in;
    logic [1:0]  uart_rxd;
    logic [1:0]  ext_intr;
    logic [3:0]  sflash_di;
    logic [15:0] strap;
    logic [5:0]  pwm_enb;
  } expect_t;

  logic clk;
  logic arst_n_i;
  logic check_en;
  logic [31:0] lfsr;
  string cur_test;
  int test_errs;
  int err_count;
  int check_count;
  int tests_run;
  int tests_failed;

  // DUT inputs
  logic [37:0] pad_in;
  logic        strap_ctrl;
  logic [31:0] multi_sel;
  logic [31:0] dir_sel;
  logic [31:0] out_type;
  logic [31:0] gpio_out;
  logic [5:0]  pwm_wfm;
  logic [1:0]  uart_txd;
  logic [3:0]  ws_txd;
  logic        sf_sck;
  logic [3:0]  sf_ss;
  logic [3:0]  sf_do;
  logic [3:0]  sf_oen;

  // DUT outputs
  logic [37:0] pad_out;
  logic [37:0] pad_oen;
  logic [31:0] gpio_in;
  logic [1:0]  uart_rxd;
  logic [1:0]  ext_intr;
  logic [3:0]  sf_di;
  logic [15:0] strap;
  logic [5:0]  pwm_enb;

  pinmux_top pinmux_top_inst (
    .pad_in_i             (pad_in),
    .cfg_strap_pad_ctrl_i (strap_ctrl),
    .cfg_multi_func_sel_i (multi_sel),
    .cfg_gpio_dir_sel_i   (dir_sel),
    .cfg_gpio_out_type_i  (out_type),
    .gpio_out_i           (gpio_out),
    .pwm_wfm_i            (pwm_wfm),
    .uart_txd_i           (uart_txd),
    .ws_txd_i             (ws_txd),
    .sflash_sck_i         (sf_sck),
    .sflash_ss_i          (sf_ss),
    .sflash_do_i          (sf_do),
    .sflash_oen_i         (sf_oen),
    .pad_out_o            (pad_out),
    .pad_oen_o            (pad_oen),
    .gpio_in_o            (gpio_in),
    .uart_rxd_o           (uart_rxd),
    .ext_intr_o           (ext_intr),
    .sflash_di_o          (sf_di),
    .strap_o              (strap),
    .pwm_enb_o            (pwm_enb)
  );

  ////////////////////////////////////////
  // Clock and reset
  ////////////////////////////////////////
  initial clk = 1'b0;
  always #2 clk = ~clk;

  initial begin
    arst_n_i = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
  end

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////
  // Feedback taps 32 22 2 and 1
  // One step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v[i] = fb;
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // Pad map copies for the model
  ////////////////////////////////////////
  // GPIO bit of a pad or -1 if none
  // A0 is bit 0 and D7 is bit 31
  function automatic int gpio_bit_of(input int p);
    if (p <= 4) return p;
    if (p == 5) return 22;
    if (p <= 10) return 24 + p - 6;
    if (p <= 12) return 14 + p - 11;
    if (p <= 15) return 29 + p - 13;
    if (p <= 21) return 8 + p - 16;
    if (p <= 27) return 16 + p - 22;
    return -1;
  endfunction

  function automatic int pwm_slot_of(input int p);
    case (p)
      9:       return 0;
      13:      return 1;
      14:      return 2;
      17:      return 3;
      18:      return 4;
      19:      return 5;
      default: return -1;
    endcase
  endfunction

  function automatic int tx_slot_of(input int p);
    case (p)
      7:       return 0;
      10:      return 1;
      default: return -1;
    endcase
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic expect_t ref_model(
    input logic [37:0] pin, input logic sctl, input logic [31:0] multi,
    input logic [31:0] dir, input logic [31:0] otype, input logic [31:0] gout,
    input logic [5:0] pwm, input logic [1:0] txd, input logic [3:0] ws,
    input logic sck, input logic [3:0] ss, input logic [3:0] sdo, input logic [3:0] soen);
    expect_t e;
    int      g;
    int      pi;
    int      ti;
    logic    rx_pad;
    logic    drv;
    logic    val;
    e = '0;
    for (int p = 0; p < 38; p++) begin
      g  = gpio_bit_of(p);
      pi = pwm_slot_of(p);
      ti = tx_slot_of(p);
      if (g >= 0) begin
        e.gpio_in[g] = pin[p];
      end
      // UART rx on pads 6 and 8 and interrupts on pads 8 and 9
      rx_pad = (p == 6 && multi[8]) || (p == 8 && (multi[9] || multi[6])) ||
               (p == 9 && multi[7]);
      drv = 1'b0;
      val = 1'b0;
      if (p >= 5 && p <= 20) begin
        if (sctl && p >= 13) begin
          drv = 1'b0;
        end else if (pi >= 0 && multi[pi]) begin
          drv = 1'b1;
          val = pwm[pi];
        end else if (ti >= 0 && multi[8 + ti]) begin
          drv = 1'b1;
          val = txd[ti];
        end else if (rx_pad) begin
          drv = 1'b0;
        end else if (otype[g]) begin
          drv = 1'b1;
          val = ws[(p - 5) / 4];
        end else if (dir[g]) begin
          drv = 1'b1;
          val = gout[g];
        end
        e.pad_oen[p] = !drv;
      end else if (p < 28) begin
        drv = dir[g];
        val = dir[g] & gout[g];
        e.pad_oen[p] = !drv;
      end else if (sctl || p == 37) begin
        e.pad_oen[p] = 1'b1;
      end else if (p == 28) begin
        val = sck;
        e.pad_oen[p] = 1'b0;
      end else if (p < 33) begin
        val = ss[p - 29];
        e.pad_oen[p] = 1'b0;
      end else begin
        val = sdo[p - 33];
        e.pad_oen[p] = soen[p - 33];
      end
      e.pad_out[p] = val;
    end
    e.uart_rxd  = {multi[9] & pin[8], multi[8] & pin[6]};
    // UART 1 rx takes pad 8 away from INT0
    e.ext_intr  = {multi[7] & pin[9], multi[6] & !multi[9] & pin[8]};
    e.sflash_di = pin[36:33];
    e.strap     = {pin[36:29], pin[20:13]};
    e.pwm_enb   = multi[5:0];
    return e;
  endfunction

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////
  task automatic check_val(input string what, input logic [63:0] exp,
                           input logic [63:0] act);
    check_count++;
    if (exp !== act) begin
      $display("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act);
      err_count++;
      test_errs++;
    end
  endtask

  // Compares every cycle once reset is released
  initial begin
    expect_t e;
    forever begin
      @(posedge clk);
      #3;
      if (check_en) begin
        e = ref_model(pad_in, strap_ctrl, multi_sel, dir_sel, out_type, gpio_out,
                      pwm_wfm, uart_txd, ws_txd, sf_sck, sf_ss, sf_do, sf_oen);
        check_val("pad_out_o", e.pad_out, pad_out);
        check_val("pad_oen_o", e.pad_oen, pad_oen);
        check_val("gpio_in_o", e.gpio_in, gpio_in);
        check_val("uart_rxd_o", e.uart_rxd, uart_rxd);
        check_val("ext_intr_o", e.ext_intr, ext_intr);
        check_val("sflash_di_o", e.sflash_di, sf_di);
        check_val("strap_o", e.strap, strap);
        check_val("pwm_enb_o", e.pwm_enb, pwm_enb);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  task automatic clear_inputs();
    pad_in     = '0;
    strap_ctrl = 1'b0;
    multi_sel  = '0;
    dir_sel    = '0;
    out_type   = '0;
    gpio_out   = '0;
    pwm_wfm    = '0;
    uart_txd   = '0;
    ws_txd     = '0;
    sf_sck     = 1'b0;
    sf_ss      = '0;
    sf_do      = '0;
    sf_oen     = '0;
  endtask

  task automatic randomize_all();
    pad_in     = 38'(rand_bits(38));
    strap_ctrl = 1'(rand_bits(1));
    multi_sel  = 32'(rand_bits(32));
    dir_sel    = 32'(rand_bits(32));
    out_type   = 32'(rand_bits(32));
    gpio_out   = 32'(rand_bits(32));
    pwm_wfm    = 6'(rand_bits(6));
    uart_txd   = 2'(rand_bits(2));
    ws_txd     = 4'(rand_bits(4));
    sf_sck     = 1'(rand_bits(1));
    sf_ss      = 4'(rand_bits(4));
    sf_do      = 4'(rand_bits(4));
    sf_oen     = 4'(rand_bits(4));
  endtask

  task automatic next_vector();
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  // Next edge comes after the last vector was compared
  task automatic end_test();
    @(posedge clk);
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
      $display("test %s: %0d mismatches", cur_test, test_errs);
    end else begin
      $display("test %s: ok", cur_test);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    int wait_cycles;
    lfsr         = 32'h2fa2;
    check_en     = 1'b0;
    err_count    = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "reset";
    clear_inputs();
    wait_cycles = 0;
    while (arst_n_i !== 1'b1 && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (arst_n_i !== 1'b1) begin
      $display("Timeout: reset still asserted after %0d cycles", wait_cycles);
      $display("FAIL: see errors above");
      $finish;
    end else begin
      check_en = 1'b1;

      // Only the flash pads drive when idle
      start_test("idle");
      next_vector();
      clear_inputs();
      #2;
      check_val("pad_oen_o", {1'b1, 9'h000, 28'hfffffff}, pad_oen);
      check_val("pad_out_o", 38'h0, pad_out & {1'b1, 9'h000, 28'hfffffff});
      check_val("rx and intr", 4'h0, {uart_rxd, ext_intr});
      end_test();

      start_test("gpio");
      for (int i = 0; i < 20; i++) begin
        next_vector();
        clear_inputs();
        pad_in   = 38'(rand_bits(38));
        dir_sel  = 32'(rand_bits(32));
        gpio_out = 32'(rand_bits(32));
      end
      end_test();

      // Only the 10 used function bits stay random
      start_test("priority");
      for (int i = 0; i < 40; i++) begin
        next_vector();
        randomize_all();
        strap_ctrl = 1'b0;
        multi_sel  = {22'h0, multi_sel[9:0]};
      end
      next_vector();
      multi_sel = 32'h0000_0240;
      pad_in[8] = 1'b1;
      end_test();

      start_test("strap_hold");
      for (int i = 0; i < 20; i++) begin
        next_vector();
        randomize_all();
        strap_ctrl = 1'b1;
        #2;
        check_val("strap oen", {10'h3ff, 8'hff}, {pad_oen[37:28], pad_oen[20:13]});
      end
      end_test();

      start_test("flash");
      for (int i = 0; i < 20; i++) begin
        next_vector();
        randomize_all();
        strap_ctrl = 1'b0;
      end
      end_test();

      start_test("random_sweep");
      for (int i = 0; i < 200; i++) begin
        next_vector();
        randomize_all();
      end
      end_test();

      check_en = 1'b0;
      $display("Tests: %0d run, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, check_count, err_count);
      if (err_count == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

endmodule

//--- verilog/pinmux_top.sv
/*
  Pin multiplexer top level
  Purely combinational, every output follows its inputs in the same cycle
  Header pads 5-20 come from the Arduino mux, all other pads from the aux mux
  pad_oen_o is active low
*/
module pinmux_top (
  input  pinmux_pad_pkg::pad_vec_t    pad_in_i,
  input  logic                        cfg_strap_pad_ctrl_i,
  input  pinmux_cfg_pkg::cfg_word_t   cfg_multi_func_sel_i,
  input  pinmux_cfg_pkg::cfg_word_t   cfg_gpio_dir_sel_i,
  input  pinmux_cfg_pkg::cfg_word_t   cfg_gpio_out_type_i,
  input  pinmux_pad_pkg::gpio_vec_t   gpio_out_i,
  input  pinmux_cfg_pkg::pwm_vec_t    pwm_wfm_i,
  input  pinmux_cfg_pkg::uart_vec_t   uart_txd_i,
  input  pinmux_cfg_pkg::ws_vec_t     ws_txd_i,
  input  logic                        sflash_sck_i,
  input  pinmux_cfg_pkg::sflash_vec_t sflash_ss_i,
  input  pinmux_cfg_pkg::sflash_vec_t sflash_do_i,
  input  pinmux_cfg_pkg::sflash_vec_t sflash_oen_i,
  output pinmux_pad_pkg::pad_vec_t    pad_out_o,
  output pinmux_pad_pkg::pad_vec_t    pad_oen_o,
  output pinmux_pad_pkg::gpio_vec_t   gpio_in_o,
  output pinmux_cfg_pkg::uart_vec_t   uart_rxd_o,
  output pinmux_cfg_pkg::int_vec_t    ext_intr_o,
  output pinmux_cfg_pkg::sflash_vec_t sflash_di_o,
  output pinmux_cfg_pkg::strap_t      strap_o,
  output pinmux_cfg_pkg::pwm_vec_t    pwm_enb_o
);
  import pinmux_pad_pkg::*;

  ard_vec_t ard_out;
  ard_vec_t ard_oen;
  aux_vec_t aux_out;
  aux_vec_t aux_oen;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////
  pinmux_in_route u_in_route (
    .pad_in_i             (pad_in_i),
    .cfg_multi_func_sel_i (cfg_multi_func_sel_i),
    .gpio_in_o            (gpio_in_o),
    .uart_rxd_o           (uart_rxd_o),
    .ext_intr_o           (ext_intr_o),
    .sflash_di_o          (sflash_di_o),
    .strap_o              (strap_o)
  );

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////
  pinmux_arduino_out u_arduino_out (
    .cfg_strap_pad_ctrl_i (cfg_strap_pad_ctrl_i),
    .cfg_multi_func_sel_i (cfg_multi_func_sel_i),
    .cfg_gpio_dir_sel_i   (cfg_gpio_dir_sel_i),
    .cfg_gpio_out_type_i  (cfg_gpio_out_type_i),
    .gpio_out_i           (gpio_out_i),
    .pwm_wfm_i            (pwm_wfm_i),
    .uart_txd_i           (uart_txd_i),
    .ws_txd_i             (ws_txd_i),
    .ard_out_o            (ard_out),
    .ard_oen_o            (ard_oen),
    .pwm_enb_o            (pwm_enb_o)
  );

  pinmux_aux_out u_aux_out (
    .cfg_strap_pad_ctrl_i (cfg_strap_pad_ctrl_i),
    .cfg_gpio_dir_sel_i   (cfg_gpio_dir_sel_i),
    .gpio_out_i           (gpio_out_i),
    .sflash_sck_i         (sflash_sck_i),
    .sflash_ss_i          (sflash_ss_i),
    .sflash_do_i          (sflash_do_i),
    .sflash_oen_i         (sflash_oen_i),
    .aux_out_o            (aux_out),
    .aux_oen_o            (aux_oen)
  );

  // Aux slots below ARD_FIRST are pads 0-4, the rest start at pad 21
  assign pad_out_o = {aux_out[AUX_W-1:ARD_FIRST], ard_out, aux_out[ARD_FIRST-1:0]};
  assign pad_oen_o = {aux_oen[AUX_W-1:ARD_FIRST], ard_oen, aux_oen[ARD_FIRST-1:0]};

endmodule

//--- verilog/pinmux_aux_out.sv
/*
  Output mux for pads outside the Arduino header
  Covers Port A pads 0-4 and pads 21-37, packed in that order
  Pads 21-27 are plain GPIO, 28-36 the quad flash, 37 input only
  Strap control high turns pads 28-37 into inputs with out 0
*/
module pinmux_aux_out (
  input  logic                        cfg_strap_pad_ctrl_i,
  input  pinmux_cfg_pkg::cfg_word_t   cfg_gpio_dir_sel_i,
  input  pinmux_pad_pkg::gpio_vec_t   gpio_out_i,
  input  logic                        sflash_sck_i,
  input  pinmux_cfg_pkg::sflash_vec_t sflash_ss_i,
  input  pinmux_cfg_pkg::sflash_vec_t sflash_do_i,
  input  pinmux_cfg_pkg::sflash_vec_t sflash_oen_i,
  output pinmux_pad_pkg::aux_vec_t    aux_out_o,
  output pinmux_pad_pkg::aux_vec_t    aux_oen_o
);
  import pinmux_pad_pkg::*;
  import pinmux_cfg_pkg::*;

  always_comb begin
    int   a;
    int   gbit;
    logic val;
    logic oen;

    aux_out_o = '0;
    aux_oen_o = '1;

    for (int p = 0; p < NUM_PADS; p++) begin
      // Skip the header range, packed slot index otherwise
      if ((p < ARD_FIRST) || (p > ARD_LAST)) begin
        a    = (p < ARD_FIRST) ? p : p - ARD_W;
        gbit = PAD_GPIO_BIT[p];
        val  = 1'b0;
        oen  = 1'b1;

        if (p >= SFLASH_SCK_PAD) begin
          // Flash side, held as input by strap control
          if (cfg_strap_pad_ctrl_i || (p == NUM_PADS - 1)) begin
            oen = 1'b1;
          end else if (p == SFLASH_SCK_PAD) begin
            val = sflash_sck_i;
            oen = 1'b0;
          end else if (p < SFLASH_IO_BASE) begin
            val = sflash_ss_i[p-SFLASH_SS_BASE];
            oen = 1'b0;
          end else begin
            // Data lines turn around under flash control
            val = sflash_do_i[p-SFLASH_IO_BASE];
            oen = sflash_oen_i[p-SFLASH_IO_BASE];
          end
        end else if ((gbit != NO_IDX) && cfg_gpio_dir_sel_i[gbit]) begin
          val = gpio_out_i[gbit];
          oen = 1'b0;
        end

        aux_out_o[a] = val;
        aux_oen_o[a] = oen;
      end
    end
  end

endmodule

//--- verilog/pinmux_arduino_out.sv
/*
  Output mux for the Arduino header pads 5 to 20
  Purely combinational, no clock
  Per pad priority: strap hold, PWM, UART tx, rx or interrupt input,
  WS281x, GPIO out, input
  Input pads drive out 0 with oen high, oen is active low
  All per-pad data comes from the pad tables
*/
module pinmux_arduino_out (
  input  logic                      cfg_strap_pad_ctrl_i,
  input  pinmux_cfg_pkg::cfg_word_t cfg_multi_func_sel_i,
  input  pinmux_cfg_pkg::cfg_word_t cfg_gpio_dir_sel_i,
  input  pinmux_cfg_pkg::cfg_word_t cfg_gpio_out_type_i,
  input  pinmux_pad_pkg::gpio_vec_t gpio_out_i,
  input  pinmux_cfg_pkg::pwm_vec_t  pwm_wfm_i,
  input  pinmux_cfg_pkg::uart_vec_t uart_txd_i,
  input  pinmux_cfg_pkg::ws_vec_t   ws_txd_i,
  output pinmux_pad_pkg::ard_vec_t  ard_out_o,
  output pinmux_pad_pkg::ard_vec_t  ard_oen_o,
  output pinmux_cfg_pkg::pwm_vec_t  pwm_enb_o
);
  import pinmux_pad_pkg::*;
  import pinmux_cfg_pkg::*;

  pwm_vec_t  pwm_en;
  uart_vec_t uart_en;
  int_vec_t  int_en;

  ////////////////////////////////////////
  // Enable fields
  ////////////////////////////////////////
  assign pwm_en  = cfg_multi_func_sel_i[PWM_EN_LSB +: NUM_PWM];
  assign uart_en = cfg_multi_func_sel_i[UART_EN_LSB +: NUM_UART];
  assign int_en  = cfg_multi_func_sel_i[INT_EN_LSB +: NUM_INT];

  // PWM block uses the same enables
  assign pwm_enb_o = pwm_en;

  ////////////////////////////////////////
  // Per pad priority mux
  ////////////////////////////////////////
  always_comb begin
    int   gbit;
    int   pwm_idx;
    int   tx_idx;
    int   ws_grp;
    logic strap_pad;
    logic pwm_hit;
    logic tx_hit;
    logic in_hit;
    logic drive;
    logic val;

    ard_out_o = '0;
    ard_oen_o = '1;

    for (int p = ARD_FIRST; p <= ARD_LAST; p++) begin
      gbit    = PAD_GPIO_BIT[p];
      pwm_idx = PAD_PWM_IDX[p];
      tx_idx  = PAD_UART_TX_IDX[p];
      ws_grp  = PAD_WS_GRP[p];

      // Pad classification
      strap_pad = (p >= STRAP_PAD_LO) && (p < STRAP_PAD_LO + STRAP_PADS);
      pwm_hit   = (pwm_idx != NO_IDX) && pwm_en[pwm_idx];
      tx_hit    = (tx_idx != NO_IDX) && uart_en[tx_idx];

      // Enabled receive or interrupt pad
      in_hit = (uart_en[0] && (p == UART0_RX_PAD)) ||
               (uart_en[1] && (p == UART1_RX_PAD)) ||
               (int_en[0] && (p == INT0_PAD))      ||
               (int_en[1] && (p == INT1_PAD));

      drive = 1'b0;
      val   = 1'b0;

      if (cfg_strap_pad_ctrl_i && strap_pad) begin
        // Held as input while straps are sampled
        drive = 1'b0;
      end else if (pwm_hit) begin
        drive = 1'b1;
        val   = pwm_wfm_i[pwm_idx];
      end else if (tx_hit) begin
        drive = 1'b1;
        val   = uart_txd_i[tx_idx];
      end else if (in_hit) begin
        drive = 1'b0;
      end else if (cfg_gpio_out_type_i[gbit]) begin
        // Out type set selects the WS281x serial line of the group
        drive = 1'b1;
        val   = ws_txd_i[ws_grp];
      end else if (cfg_gpio_dir_sel_i[gbit]) begin
        drive = 1'b1;
        val   = gpio_out_i[gbit];
      end

      ard_out_o[p-ARD_FIRST] = drive & val;
      ard_oen_o[p-ARD_FIRST] = !drive;
    end
  end

endmodule

//--- verilog/pinmux_in_route.sv
/*
  Pad input routing
  Purely combinational, no clock
  GPIO inputs always see their pad, function inputs read 0 when disabled
  Strap and flash data lines are not gated by any enable
*/
module pinmux_in_route (
  input  pinmux_pad_pkg::pad_vec_t    pad_in_i,
  input  pinmux_cfg_pkg::cfg_word_t   cfg_multi_func_sel_i,
  output pinmux_pad_pkg::gpio_vec_t   gpio_in_o,
  output pinmux_cfg_pkg::uart_vec_t   uart_rxd_o,
  output pinmux_cfg_pkg::int_vec_t    ext_intr_o,
  output pinmux_cfg_pkg::sflash_vec_t sflash_di_o,
  output pinmux_cfg_pkg::strap_t      strap_o
);
  import pinmux_pad_pkg::*;
  import pinmux_cfg_pkg::*;

  uart_vec_t uart_en;
  int_vec_t  int_en;
  logic      int0_free;

  // Function enables
  assign uart_en = cfg_multi_func_sel_i[UART_EN_LSB +: NUM_UART];
  assign int_en  = cfg_multi_func_sel_i[INT_EN_LSB +: NUM_INT];

  ////////////////////////////////////////
  // GPIO port inputs
  ////////////////////////////////////////
  always_comb begin
    // Unmapped bits A5-A7 and C7 stay low
    gpio_in_o = '0;
    for (int p = 0; p < NUM_PADS; p++) begin
      if (PAD_GPIO_BIT[p] != NO_IDX) begin
        gpio_in_o[PAD_GPIO_BIT[p]] = pad_in_i[p];
      end
    end
  end

  ////////////////////////////////////////
  // UART receive and interrupts
  ////////////////////////////////////////
  assign uart_rxd_o[0] = uart_en[0] ? pad_in_i[UART0_RX_PAD] : 1'b0;
  assign uart_rxd_o[1] = uart_en[1] ? pad_in_i[UART1_RX_PAD] : 1'b0;

  // INT0 loses its pad to UART 1 receive when they share it
  assign int0_free = !(uart_en[1] && (INT0_PAD == UART1_RX_PAD));

  assign ext_intr_o[0] = (int_en[0] && int0_free) ? pad_in_i[INT0_PAD] : 1'b0;
  assign ext_intr_o[1] = int_en[1] ? pad_in_i[INT1_PAD] : 1'b0;

  ////////////////////////////////////////
  // Flash data and straps
  ////////////////////////////////////////
  assign sflash_di_o = pad_in_i[SFLASH_IO_BASE +: SFLASH_W];

  // strap[15:8] from the flash pads, strap[7:0] from the header pads
  assign strap_o = {pad_in_i[STRAP_PAD_HI +: STRAP_PADS],
                    pad_in_i[STRAP_PAD_LO +: STRAP_PADS]};

endmodule

//--- verilog/pinmux_cfg_pkg.sv
/*
  Config word layout of the pin multiplexer
  Three 32-bit words: multi-function select, GPIO direction, GPIO out type
  Direction and out-type words are indexed by GPIO bit, not by pad
  Multi-function bits above the UART enables are unused
*/
package pinmux_cfg_pkg;

  ////////////////////////////////////////
  // Function counts
  ////////////////////////////////////////
  localparam int CFG_W    = 32;
  localparam int NUM_PWM  = 6;
  localparam int NUM_UART = 2;
  localparam int NUM_INT  = 2;
  localparam int NUM_WS   = 4;
  localparam int SFLASH_W = 4;
  // High strap pads above low strap pads
  localparam int STRAP_W  = 16;

  typedef logic [CFG_W-1:0]    cfg_word_t;
  typedef logic [NUM_PWM-1:0]  pwm_vec_t;
  typedef logic [NUM_UART-1:0] uart_vec_t;
  typedef logic [NUM_INT-1:0]  int_vec_t;
  typedef logic [NUM_WS-1:0]   ws_vec_t;
  typedef logic [SFLASH_W-1:0] sflash_vec_t;
  typedef logic [STRAP_W-1:0]  strap_t;

  ////////////////////////////////////////
  // Multi-function word fields
  ////////////////////////////////////////
  // PWM enables, one per PWM slot
  localparam int PWM_EN_LSB  = 0;
  // Level interrupt enables
  localparam int INT_EN_LSB  = 6;
  // UART enables, cover both rx and tx pads
  localparam int UART_EN_LSB = 8;

endpackage

//--- verilog/pinmux_pad_pkg.sv
/*
  Pad map of the pin multiplexer
  38 pads, four 8-bit GPIO ports packed A, B, C, D from bit 0 upward
  Tables are indexed by pad number, NO_IDX marks a pad without that function
  Adding a pad function means editing the tables here, not the routing code
*/
package pinmux_pad_pkg;

  ////////////////////////////////////////
  // Pad and port sizes
  ////////////////////////////////////////
  localparam int NUM_PADS  = 38;
  localparam int GPIO_W    = 32;
  localparam int ARD_FIRST = 5;
  localparam int ARD_LAST  = 20;
  localparam int ARD_W     = ARD_LAST - ARD_FIRST + 1;
  // Pads outside the Arduino header range
  localparam int AUX_W     = NUM_PADS - ARD_W;
  localparam int NO_IDX    = -1;

  typedef logic [NUM_PADS-1:0] pad_vec_t;
  typedef logic [GPIO_W-1:0]   gpio_vec_t;
  typedef logic [ARD_W-1:0]    ard_vec_t;
  typedef logic [AUX_W-1:0]    aux_vec_t;

  ////////////////////////////////////////
  // Routing tables, one entry per pad
  ////////////////////////////////////////
  // GPIO bit: A0 = 0, B0 = 8, C0 = 16, D0 = 24
  localparam int PAD_GPIO_BIT [NUM_PADS] = '{
    0: 0, 1: 1, 2: 2, 3: 3, 4: 4,
    5: 22,
    6: 24, 7: 25, 8: 26, 9: 27, 10: 28,
    11: 14, 12: 15,
    13: 29, 14: 30, 15: 31,
    16: 8, 17: 9, 18: 10, 19: 11, 20: 12, 21: 13,
    22: 16, 23: 17, 24: 18, 25: 19, 26: 20, 27: 21,
    default: NO_IDX
  };

  // WS281x group, four pads per group
  localparam int PAD_WS_GRP [NUM_PADS] = '{
    5: 0, 6: 0, 7: 0, 8: 0,
    9: 1, 10: 1, 11: 1, 12: 1,
    13: 2, 14: 2, 15: 2, 16: 2,
    17: 3, 18: 3, 19: 3, 20: 3,
    default: NO_IDX
  };

  localparam int PAD_PWM_IDX [NUM_PADS] = '{
    9: 0, 13: 1, 14: 2, 17: 3, 18: 4, 19: 5, default: NO_IDX
  };

  localparam int PAD_UART_TX_IDX [NUM_PADS] = '{7: 0, 10: 1, default: NO_IDX};

  ////////////////////////////////////////
  // Fixed input pads
  ////////////////////////////////////////
  localparam int UART0_RX_PAD = 6;
  // Shared with INT0, UART 1 wins
  localparam int UART1_RX_PAD = 8;
  localparam int INT0_PAD     = 8;
  localparam int INT1_PAD     = 9;

  // Strap groups, eight pads each
  localparam int STRAP_PAD_LO = 13;
  localparam int STRAP_PAD_HI = 29;
  localparam int STRAP_PADS   = 8;

  // Quad serial flash
  localparam int SFLASH_SCK_PAD = 28;
  localparam int SFLASH_SS_BASE = 29;
  localparam int SFLASH_IO_BASE = 33;

endpackage
